//--- rtl/scene_pkg.sv
package scene_pkg;

    // ========================================================================
    // word widths
    // ========================================================================
    localparam int COORD_W = 16;          // one fixed-point coordinate
    localparam int VTX_W   = 3 * COORD_W; // x, y, z
    localparam int TRANS_W = 9 * COORD_W; // 3x3 matrix, row major

    // ========================================================================
    // host opcodes
    // ========================================================================
    typedef enum logic [3:0] {
        OP_WIPE        = 4'd0,
        OP_VERT_HDR    = 4'd1,
        OP_TRI_HDR     = 4'd2,
        OP_CREATE_INST = 4'd3,
        OP_UPDATE_INST = 4'd4
    } scene_op_t;

    // loader FSM states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WIPE,
        ST_VERT_HDR,
        ST_VERT_DATA,
        ST_TRI_HDR,
        ST_TRI_DATA,
        ST_INST
    } loader_state_t;

endpackage

//--- rtl/sdp_ram.sv
`timescale 1ns/1ps

module sdp_ram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 1024
) (
    input  logic                     sck,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  logic [WIDTH-1:0]         wr_data,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output logic [WIDTH-1:0]         rd_data
);

    logic [WIDTH-1:0] mem [DEPTH];

    // single clock, one write port and one read port
    always_ff @(posedge sck) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr]; // old word on a same-address hit
    end

endmodule

//--- rtl/desc_table.sv
`timescale 1ns/1ps

module desc_table #(
    parameter int ENTRIES = 16,
    parameter int BASE_W  = 10,
    parameter int CNT_W   = 9
) (
    input  logic                       sck,
    input  logic                       rst,
    input  logic                       clear,
    input  logic [$clog2(ENTRIES)-1:0] clear_idx,
    input  logic                       wr_en,
    input  logic [$clog2(ENTRIES)-1:0] wr_idx,
    input  logic [BASE_W-1:0]          wr_base,
    input  logic [CNT_W-1:0]           wr_count,
    input  logic [$clog2(ENTRIES)-1:0] rd_idx,
    output logic [BASE_W-1:0]          rd_base,
    output logic [CNT_W-1:0]           rd_count
);

    logic [BASE_W-1:0] base_q  [ENTRIES];
    logic [CNT_W-1:0]  count_q [ENTRIES];

    always_ff @(posedge sck) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                base_q[i]  <= '0;
                count_q[i] <= '0; // unused buffers read as empty
            end
        end else begin
            if (clear) begin // wipe sweep, one entry a cycle
                base_q[clear_idx]  <= '0;
                count_q[clear_idx] <= '0;
            end
            if (wr_en) begin
                base_q[wr_idx]  <= wr_base;
                count_q[wr_idx] <= wr_count;
            end
        end
    end

    always_ff @(posedge sck) begin
        rd_base  <= base_q[rd_idx];
        rd_count <= count_q[rd_idx];
    end

endmodule

//--- rtl/scene_loader.sv
`timescale 1ns/1ps

module scene_loader import scene_pkg::*; #(
    parameter int VERT_DEPTH = 1024,
    parameter int TRI_DEPTH  = 1024,
    parameter int INST_NUM   = 64,
    parameter int VBUF_NUM   = 16,
    parameter int TBUF_NUM   = 16,
    parameter int MAX_CNT    = 256,
    parameter int VA_W  = $clog2(VERT_DEPTH),
    parameter int TA_W  = $clog2(TRI_DEPTH),
    parameter int IID_W = $clog2(INST_NUM),
    parameter int VB_W  = $clog2(VBUF_NUM),
    parameter int TB_W  = $clog2(TBUF_NUM),
    parameter int CNT_W = $clog2(MAX_CNT) + 1,
    parameter int TRI_W = 3 * $clog2(MAX_CNT),
    parameter int CLR_N = (VBUF_NUM > TBUF_NUM) ? VBUF_NUM : TBUF_NUM,
    parameter int CLR_W = $clog2(CLR_N)
) (
    input  logic               sck,
    input  logic               rst,
    // host side
    input  logic               opcode_valid,
    input  logic [3:0]         opcode,
    input  logic               vert_hdr_valid,
    input  logic [VB_W-1:0]    vert_buf_id,
    input  logic [VA_W-1:0]    vert_base,
    input  logic [CNT_W-1:0]   vert_count,
    input  logic               vert_valid,
    input  logic [VTX_W-1:0]   vert_in,
    input  logic               tri_hdr_valid,
    input  logic [TB_W-1:0]    tri_buf_id,
    input  logic [TA_W-1:0]    tri_base,
    input  logic [CNT_W-1:0]   tri_count,
    input  logic               tri_valid,
    input  logic [TRI_W-1:0]   tri_in,
    input  logic               inst_valid,
    input  logic [IID_W-1:0]   inst_id_in,
    input  logic [VB_W-1:0]    inst_vbuf,
    input  logic [TB_W-1:0]    inst_tbuf,
    input  logic [TRANS_W-1:0] transform_in,
    output logic               busy,
    // write side
    output logic               vert_we,
    output logic [VA_W-1:0]    vert_waddr,
    output logic [VTX_W-1:0]   vert_wdata,
    output logic               tri_we,
    output logic [TA_W-1:0]    tri_waddr,
    output logic [TRI_W-1:0]   tri_wdata,
    output logic               xform_we,
    output logic [IID_W-1:0]   xform_waddr,
    output logic [TRANS_W-1:0] xform_wdata,
    output logic               link_we,
    output logic [IID_W-1:0]   link_idx,
    output logic [VB_W-1:0]    link_vbuf,
    output logic [TB_W-1:0]    link_tbuf,
    output logic               vdesc_we,
    output logic [VB_W-1:0]    vdesc_idx,
    output logic [VA_W-1:0]    vdesc_base,
    output logic [CNT_W-1:0]   vdesc_count,
    output logic               tdesc_we,
    output logic [TB_W-1:0]    tdesc_idx,
    output logic [TA_W-1:0]    tdesc_base,
    output logic [CNT_W-1:0]   tdesc_count,
    output logic               desc_clear,
    output logic [CLR_W-1:0]   clear_idx
);

    loader_state_t    state;
    logic [VA_W-1:0]  v_base;    // latched from header
    logic [TA_W-1:0]  t_base;
    logic [CNT_W-1:0] cur_cnt;
    logic [CNT_W-1:0] ctr;       // words taken so far
    logic [CLR_W-1:0] clr_cnt;
    logic             inst_create; // create vs update

    // a registered write still in flight keeps the host held off
    assign busy = (state != ST_IDLE) | vert_we | tri_we | xform_we | link_we
                | vdesc_we | tdesc_we;

    assign desc_clear = (state == ST_WIPE);
    assign clear_idx  = clr_cnt;

    always_ff @(posedge sck) begin
        if (rst) begin
            state       <= ST_IDLE;
            vert_we     <= 1'b0;
            tri_we      <= 1'b0;
            xform_we    <= 1'b0;
            link_we     <= 1'b0;
            vdesc_we    <= 1'b0;
            tdesc_we    <= 1'b0;
            ctr         <= '0;
            clr_cnt     <= '0;
            inst_create <= 1'b0;
        end else begin
            vert_we  <= 1'b0; // strobes last one cycle
            tri_we   <= 1'b0;
            xform_we <= 1'b0;
            link_we  <= 1'b0;
            vdesc_we <= 1'b0;
            tdesc_we <= 1'b0;

            case (state)
                ST_IDLE: if (opcode_valid && !busy) begin
                    case (scene_op_t'(opcode))
                        OP_WIPE: begin
                            clr_cnt <= '0;
                            state   <= ST_WIPE;
                        end
                        OP_VERT_HDR:    state <= ST_VERT_HDR;
                        OP_TRI_HDR:     state <= ST_TRI_HDR;
                        OP_CREATE_INST: begin
                            inst_create <= 1'b1;
                            state       <= ST_INST;
                        end
                        OP_UPDATE_INST: begin
                            inst_create <= 1'b0;
                            state       <= ST_INST;
                        end
                        default: state <= ST_IDLE; // unknown code dropped
                    endcase
                end

                ST_WIPE: begin
                    clr_cnt <= clr_cnt + 1'b1;
                    if (clr_cnt == CLR_W'(CLR_N - 1)) begin
                        state <= ST_IDLE;
                    end
                end

                ST_VERT_HDR: if (vert_hdr_valid) begin
                    vdesc_we    <= 1'b1;
                    vdesc_idx   <= vert_buf_id;
                    vdesc_base  <= vert_base;
                    vdesc_count <= vert_count;
                    v_base      <= vert_base;
                    cur_cnt     <= vert_count;
                    ctr         <= '0;
                    state       <= (vert_count == '0) ? ST_IDLE : ST_VERT_DATA;
                end

                ST_VERT_DATA: if (vert_valid) begin
                    vert_we    <= 1'b1;
                    vert_waddr <= v_base + VA_W'(ctr); // wraps on depth
                    vert_wdata <= vert_in;
                    ctr        <= ctr + 1'b1;
                    if (ctr + 1'b1 == cur_cnt) begin
                        state <= ST_IDLE;
                    end
                end

                ST_TRI_HDR: if (tri_hdr_valid) begin
                    tdesc_we    <= 1'b1;
                    tdesc_idx   <= tri_buf_id;
                    tdesc_base  <= tri_base;
                    tdesc_count <= tri_count;
                    t_base      <= tri_base;
                    cur_cnt     <= tri_count;
                    ctr         <= '0;
                    state       <= (tri_count == '0) ? ST_IDLE : ST_TRI_DATA;
                end

                ST_TRI_DATA: if (tri_valid) begin
                    tri_we    <= 1'b1;
                    tri_waddr <= t_base + TA_W'(ctr);
                    tri_wdata <= tri_in;
                    ctr       <= ctr + 1'b1;
                    if (ctr + 1'b1 == cur_cnt) begin
                        state <= ST_IDLE;
                    end
                end

                ST_INST: if (inst_valid) begin
                    xform_we    <= 1'b1;
                    xform_waddr <= inst_id_in;
                    xform_wdata <= transform_in;
                    link_we     <= inst_create; // update keeps the links
                    link_idx    <= inst_id_in;
                    link_vbuf   <= inst_vbuf;
                    link_tbuf   <= inst_tbuf;
                    state       <= ST_IDLE;
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- rtl/inst_lookup.sv
`timescale 1ns/1ps

module inst_lookup import scene_pkg::*; #(
    parameter int INST_NUM = 64,
    parameter int VBUF_NUM = 16,
    parameter int TBUF_NUM = 16,
    parameter int IID_W = $clog2(INST_NUM),
    parameter int VB_W  = $clog2(VBUF_NUM),
    parameter int TB_W  = $clog2(TBUF_NUM)
) (
    input  logic               sck,
    input  logic               rst,
    input  logic               link_we,
    input  logic [IID_W-1:0]   link_idx,
    input  logic [VB_W-1:0]    link_vbuf,
    input  logic [TB_W-1:0]    link_tbuf,
    input  logic               draw_valid,
    input  logic [IID_W-1:0]   draw_inst_id,
    output logic [IID_W-1:0]   xform_rd_addr,
    input  logic [TRANS_W-1:0] xform_rd_data,
    output logic [VB_W-1:0]    vdesc_rd_idx,
    output logic [TB_W-1:0]    tdesc_rd_idx,
    output logic               draw_rsp_valid,
    output logic [TRANS_W-1:0] draw_transform
);

    logic [VB_W-1:0] vbuf_link [INST_NUM];
    logic [TB_W-1:0] tbuf_link [INST_NUM];
    logic            s1_valid;
    logic            s2_valid;

    always_ff @(posedge sck) begin
        if (link_we) begin
            vbuf_link[link_idx] <= link_vbuf;
            tbuf_link[link_idx] <= link_tbuf;
        end
    end

    // ========================================================================
    // stage 1: transform RAM and link read, stage 2: descriptor read
    // ========================================================================
    assign xform_rd_addr = draw_inst_id;

    always_ff @(posedge sck) begin
        vdesc_rd_idx   <= vbuf_link[draw_inst_id];
        tdesc_rd_idx   <= tbuf_link[draw_inst_id];
        draw_transform <= xform_rd_data; // lines up with the descriptors
    end

    always_ff @(posedge sck) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= draw_valid;
            s2_valid <= s1_valid;
        end
    end

    assign draw_rsp_valid = s2_valid;

endmodule

//--- rtl/scene_mem.sv
`timescale 1ns/1ps

module scene_mem import scene_pkg::*; #(
    parameter int VERT_DEPTH = 1024,
    parameter int TRI_DEPTH  = 1024,
    parameter int INST_NUM   = 64,
    parameter int VBUF_NUM   = 16,
    parameter int TBUF_NUM   = 16,
    parameter int MAX_CNT    = 256,
    parameter int VA_W  = $clog2(VERT_DEPTH),
    parameter int TA_W  = $clog2(TRI_DEPTH),
    parameter int IID_W = $clog2(INST_NUM),
    parameter int VB_W  = $clog2(VBUF_NUM),
    parameter int TB_W  = $clog2(TBUF_NUM),
    parameter int CNT_W = $clog2(MAX_CNT) + 1,
    parameter int TRI_W = 3 * $clog2(MAX_CNT),
    parameter int CLR_W = $clog2((VBUF_NUM > TBUF_NUM) ? VBUF_NUM : TBUF_NUM)
) (
    input  logic               sck,
    input  logic               rst,
    // host commands
    input  logic               opcode_valid,
    input  logic [3:0]         opcode,
    input  logic               vert_hdr_valid,
    input  logic [VB_W-1:0]    vert_buf_id,
    input  logic [VA_W-1:0]    vert_base,
    input  logic [CNT_W-1:0]   vert_count,
    input  logic               vert_valid,
    input  logic [VTX_W-1:0]   vert_in,
    input  logic               tri_hdr_valid,
    input  logic [TB_W-1:0]    tri_buf_id,
    input  logic [TA_W-1:0]    tri_base,
    input  logic [CNT_W-1:0]   tri_count,
    input  logic               tri_valid,
    input  logic [TRI_W-1:0]   tri_in,
    input  logic               inst_valid,
    input  logic [IID_W-1:0]   inst_id_in,
    input  logic [VB_W-1:0]    inst_vbuf,
    input  logic [TB_W-1:0]    inst_tbuf,
    input  logic [TRANS_W-1:0] transform_in,
    output logic               busy,
    // draw side
    input  logic               draw_valid,
    input  logic [IID_W-1:0]   draw_inst_id,
    output logic               draw_rsp_valid,
    output logic [TRANS_W-1:0] draw_transform,
    output logic [VA_W-1:0]    draw_vert_base,
    output logic [CNT_W-1:0]   draw_vert_count,
    output logic [TA_W-1:0]    draw_tri_base,
    output logic [CNT_W-1:0]   draw_tri_count,
    // raw reads
    input  logic [VA_W-1:0]    vert_rd_addr,
    output logic [VTX_W-1:0]   vert_rd_data,
    input  logic [TA_W-1:0]    tri_rd_addr,
    output logic [TRI_W-1:0]   tri_rd_data
);

    logic               vert_we, tri_we, xform_we, link_we;
    logic [VA_W-1:0]    vert_waddr;
    logic [VTX_W-1:0]   vert_wdata;
    logic [TA_W-1:0]    tri_waddr;
    logic [TRI_W-1:0]   tri_wdata;
    logic [IID_W-1:0]   xform_waddr, link_idx, xform_rd_addr;
    logic [TRANS_W-1:0] xform_wdata, xform_rd_data;
    logic [VB_W-1:0]    link_vbuf, vdesc_idx, vdesc_rd_idx;
    logic [TB_W-1:0]    link_tbuf, tdesc_idx, tdesc_rd_idx;
    logic               vdesc_we, tdesc_we, desc_clear;
    logic [VA_W-1:0]    vdesc_base;
    logic [TA_W-1:0]    tdesc_base;
    logic [CNT_W-1:0]   vdesc_count, tdesc_count;
    logic [CLR_W-1:0]   clear_idx;

    // ========================================================================
    // memories
    // ========================================================================
    sdp_ram #(.WIDTH(VTX_W), .DEPTH(VERT_DEPTH)) vert_ram (
        .sck(sck), .wr_en(vert_we), .wr_addr(vert_waddr), .wr_data(vert_wdata),
        .rd_addr(vert_rd_addr), .rd_data(vert_rd_data)
    );

    sdp_ram #(.WIDTH(TRI_W), .DEPTH(TRI_DEPTH)) tri_ram (
        .sck(sck), .wr_en(tri_we), .wr_addr(tri_waddr), .wr_data(tri_wdata),
        .rd_addr(tri_rd_addr), .rd_data(tri_rd_data)
    );

    sdp_ram #(.WIDTH(TRANS_W), .DEPTH(INST_NUM)) xform_ram (
        .sck(sck), .wr_en(xform_we), .wr_addr(xform_waddr), .wr_data(xform_wdata),
        .rd_addr(xform_rd_addr), .rd_data(xform_rd_data)
    );

    // the smaller table takes the low bits of the shared sweep counter
    desc_table #(.ENTRIES(VBUF_NUM), .BASE_W(VA_W), .CNT_W(CNT_W)) vert_desc (
        .sck(sck), .rst(rst), .clear(desc_clear), .clear_idx(clear_idx[VB_W-1:0]),
        .wr_en(vdesc_we), .wr_idx(vdesc_idx), .wr_base(vdesc_base),
        .wr_count(vdesc_count), .rd_idx(vdesc_rd_idx),
        .rd_base(draw_vert_base), .rd_count(draw_vert_count)
    );

    desc_table #(.ENTRIES(TBUF_NUM), .BASE_W(TA_W), .CNT_W(CNT_W)) tri_desc (
        .sck(sck), .rst(rst), .clear(desc_clear), .clear_idx(clear_idx[TB_W-1:0]),
        .wr_en(tdesc_we), .wr_idx(tdesc_idx), .wr_base(tdesc_base),
        .wr_count(tdesc_count), .rd_idx(tdesc_rd_idx),
        .rd_base(draw_tri_base), .rd_count(draw_tri_count)
    );

    // ========================================================================
    // host loader and draw-side lookup
    // ========================================================================
    scene_loader #(
        .VERT_DEPTH(VERT_DEPTH), .TRI_DEPTH(TRI_DEPTH), .INST_NUM(INST_NUM),
        .VBUF_NUM(VBUF_NUM), .TBUF_NUM(TBUF_NUM), .MAX_CNT(MAX_CNT)
    ) scene_loader_inst (
        .sck(sck), .rst(rst), .opcode_valid(opcode_valid), .opcode(opcode),
        .vert_hdr_valid(vert_hdr_valid), .vert_buf_id(vert_buf_id),
        .vert_base(vert_base), .vert_count(vert_count),
        .vert_valid(vert_valid), .vert_in(vert_in),
        .tri_hdr_valid(tri_hdr_valid), .tri_buf_id(tri_buf_id),
        .tri_base(tri_base), .tri_count(tri_count),
        .tri_valid(tri_valid), .tri_in(tri_in),
        .inst_valid(inst_valid), .inst_id_in(inst_id_in), .inst_vbuf(inst_vbuf),
        .inst_tbuf(inst_tbuf), .transform_in(transform_in), .busy(busy),
        .vert_we(vert_we), .vert_waddr(vert_waddr), .vert_wdata(vert_wdata),
        .tri_we(tri_we), .tri_waddr(tri_waddr), .tri_wdata(tri_wdata),
        .xform_we(xform_we), .xform_waddr(xform_waddr), .xform_wdata(xform_wdata),
        .link_we(link_we), .link_idx(link_idx), .link_vbuf(link_vbuf),
        .link_tbuf(link_tbuf), .vdesc_we(vdesc_we), .vdesc_idx(vdesc_idx),
        .vdesc_base(vdesc_base), .vdesc_count(vdesc_count),
        .tdesc_we(tdesc_we), .tdesc_idx(tdesc_idx), .tdesc_base(tdesc_base),
        .tdesc_count(tdesc_count), .desc_clear(desc_clear), .clear_idx(clear_idx)
    );

    inst_lookup #(
        .INST_NUM(INST_NUM), .VBUF_NUM(VBUF_NUM), .TBUF_NUM(TBUF_NUM)
    ) inst_lookup_inst (
        .sck(sck), .rst(rst), .link_we(link_we), .link_idx(link_idx),
        .link_vbuf(link_vbuf), .link_tbuf(link_tbuf),
        .draw_valid(draw_valid), .draw_inst_id(draw_inst_id),
        .xform_rd_addr(xform_rd_addr), .xform_rd_data(xform_rd_data),
        .vdesc_rd_idx(vdesc_rd_idx), .tdesc_rd_idx(tdesc_rd_idx),
        .draw_rsp_valid(draw_rsp_valid), .draw_transform(draw_transform)
    );

endmodule

//--- testbench/tb_scene_mem.sv
`timescale 1ns/1ps

module tb_scene_mem import scene_pkg::*; ();

    localparam int VERT_DEPTH = 1024;
    localparam int TRI_DEPTH  = 1024;
    localparam int INST_NUM   = 64;
    localparam int VBUF_NUM   = 16;
    localparam int TBUF_NUM   = 16;
    localparam int MAX_CNT    = 256;
    localparam int VA_W  = $clog2(VERT_DEPTH);
    localparam int TA_W  = $clog2(TRI_DEPTH);
    localparam int IID_W = $clog2(INST_NUM);
    localparam int VB_W  = $clog2(VBUF_NUM);
    localparam int TB_W  = $clog2(TBUF_NUM);
    localparam int CNT_W = $clog2(MAX_CNT) + 1;
    localparam int TRI_W = 3 * $clog2(MAX_CNT);
    localparam int CLR_N = (VBUF_NUM > TBUF_NUM) ? VBUF_NUM : TBUF_NUM;
    localparam logic [3:0] CHECK_ALL = 4'hf; // table only, never sent

    typedef struct packed {
        logic [3:0] op;
        logic [7:0] id;      // buffer or instance id
        logic [9:0] base;
        logic [8:0] count;
        logic [3:0] extra;   // words past count
        logic       busy_op; // wipe opcode held while busy
        logic [3:0] vbuf;
        logic [3:0] tbuf;
    } row_t;

    logic sck, rst, opcode_valid, vert_hdr_valid, vert_valid, tri_hdr_valid, tri_valid;
    logic inst_valid, busy, draw_valid, draw_rsp_valid;
    logic [3:0]         opcode;
    logic [VB_W-1:0]    vert_buf_id, inst_vbuf;
    logic [TB_W-1:0]    tri_buf_id, inst_tbuf;
    logic [VA_W-1:0]    vert_base, draw_vert_base, vert_rd_addr;
    logic [TA_W-1:0]    tri_base, draw_tri_base, tri_rd_addr;
    logic [CNT_W-1:0]   vert_count, tri_count, draw_vert_count, draw_tri_count;
    logic [VTX_W-1:0]   vert_in, vert_rd_data;
    logic [TRI_W-1:0]   tri_in, tri_rd_data;
    logic [IID_W-1:0]   inst_id_in, draw_inst_id;
    logic [TRANS_W-1:0] transform_in, draw_transform;

    // reference model
    logic [VTX_W-1:0]   m_vert [VERT_DEPTH];
    bit                 m_vert_ok [VERT_DEPTH];
    logic [TRI_W-1:0]   m_tri [TRI_DEPTH];
    bit                 m_tri_ok [TRI_DEPTH];
    logic [VA_W-1:0]    m_vbase [VBUF_NUM];
    logic [CNT_W-1:0]   m_vcnt [VBUF_NUM];
    logic [TA_W-1:0]    m_tbase [TBUF_NUM];
    logic [CNT_W-1:0]   m_tcnt [TBUF_NUM];
    logic [VB_W-1:0]    m_link_v [INST_NUM];
    logic [TB_W-1:0]    m_link_t [INST_NUM];
    logic [TRANS_W-1:0] m_xform [INST_NUM];
    bit                 m_inst_ok [INST_NUM];
    logic [31:0]        lfsr_state;
    row_t               rows [$];

    scene_mem #(
        .VERT_DEPTH(VERT_DEPTH), .TRI_DEPTH(TRI_DEPTH), .INST_NUM(INST_NUM),
        .VBUF_NUM(VBUF_NUM), .TBUF_NUM(TBUF_NUM), .MAX_CNT(MAX_CNT)
    ) scene_mem_inst (.*);

    always #5 sck = ~sck;

    // ========================================================================
    // helpers
    // ========================================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [TRANS_W-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[TRANS_W-2:0], lfsr_state[0]}; // one step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "first failure ends the run");
    endtask

    task automatic check_value(input string name, input logic [TRANS_W-1:0] got,
                               input logic [TRANS_W-1:0] exp);
        assert (got === exp) else
            stop_with_failure($sformatf("error at %0d ns: %s expected %h got %h",
                                        $time, name, exp, got));
    endtask

    task automatic next_cycle();
        @(posedge sck);
        #1; // inputs change just after the edge
    endtask

    task automatic wait_idle(output int high_cycles);
        int n;
        n = 0;
        while (busy) begin
            n++;
            if (n > 2 * MAX_CNT + 64) begin
                stop_with_failure("timeout: busy did not fall after a command");
            end
            next_cycle();
        end
        high_cycles = n;
    endtask

    task automatic send_opcode(input logic [3:0] op);
        int n;
        wait_idle(n);
        opcode_valid = 1'b1;
        opcode       = op;
        next_cycle();
        opcode_valid = 1'b0;
        check_value("busy", busy, 1'b1);
    endtask

    // ========================================================================
    // commands
    // ========================================================================
    task automatic load_buffer(input row_t r);
        logic [TRANS_W-1:0] w;
        int n;
        int addr;
        send_opcode(r.op);
        if (r.op == OP_VERT_HDR) begin
            vert_hdr_valid = 1'b1;
            vert_buf_id    = r.id[VB_W-1:0];
            vert_base      = r.base;
            vert_count     = r.count;
            m_vbase[r.id]  = r.base;
            m_vcnt[r.id]   = r.count;
        end else begin
            tri_hdr_valid = 1'b1;
            tri_buf_id    = r.id[TB_W-1:0];
            tri_base      = r.base;
            tri_count     = r.count;
            m_tbase[r.id] = r.base;
            m_tcnt[r.id]  = r.count;
        end
        next_cycle();
        vert_hdr_valid = 1'b0;
        tri_hdr_valid  = 1'b0;
        for (int i = 0; i < r.count + r.extra; i++) begin
            if (r.busy_op && i <= r.count) begin
                check_value("busy", busy, 1'b1);
                opcode_valid = 1'b1; // a wipe here must be dropped
                opcode       = OP_WIPE;
            end else begin
                opcode_valid = 1'b0;
            end
            if (r.op == OP_VERT_HDR) begin
                take_bits(VTX_W, w);
                vert_valid = 1'b1;
                vert_in    = w[VTX_W-1:0];
                addr       = (r.base + i) % VERT_DEPTH;
                if (i < r.count) begin
                    m_vert[addr]    = w[VTX_W-1:0];
                    m_vert_ok[addr] = 1'b1;
                end
            end else begin
                take_bits(TRI_W, w);
                tri_valid = 1'b1;
                tri_in    = w[TRI_W-1:0];
                addr      = (r.base + i) % TRI_DEPTH;
                if (i < r.count) begin
                    m_tri[addr]    = w[TRI_W-1:0];
                    m_tri_ok[addr] = 1'b1;
                end
            end
            next_cycle();
        end
        vert_valid   = 1'b0;
        tri_valid    = 1'b0;
        opcode_valid = 1'b0;
        wait_idle(n);
    endtask

    task automatic instance_cmd(input row_t r);
        logic [TRANS_W-1:0] w;
        int n;
        send_opcode(r.op);
        take_bits(TRANS_W, w);
        inst_valid   = 1'b1;
        inst_id_in   = r.id[IID_W-1:0];
        inst_vbuf    = r.vbuf[VB_W-1:0];
        inst_tbuf    = r.tbuf[TB_W-1:0];
        transform_in = w;
        next_cycle();
        inst_valid = 1'b0;
        m_xform[r.id] = w;
        if (r.op == OP_CREATE_INST) begin // update leaves the links alone
            m_link_v[r.id]  = r.vbuf[VB_W-1:0];
            m_link_t[r.id]  = r.tbuf[TB_W-1:0];
            m_inst_ok[r.id] = 1'b1;
        end
        wait_idle(n);
    endtask

    task automatic wipe_tables();
        int n;
        send_opcode(OP_WIPE);
        wait_idle(n);
        check_value("wipe busy cycles", n, CLR_N);
        for (int i = 0; i < VBUF_NUM; i++) begin
            m_vbase[i] = '0;
            m_vcnt[i]  = '0;
        end
        for (int i = 0; i < TBUF_NUM; i++) begin
            m_tbase[i] = '0;
            m_tcnt[i]  = '0;
        end
    endtask

    task automatic check_memories();
        for (int a = 0; a < VERT_DEPTH; a++) begin
            if (m_vert_ok[a]) begin
                vert_rd_addr = a;
                next_cycle();
                check_value($sformatf("vert_rd_data[%0d]", a), vert_rd_data, m_vert[a]);
            end
        end
        for (int a = 0; a < TRI_DEPTH; a++) begin
            if (m_tri_ok[a]) begin
                tri_rd_addr = a;
                next_cycle();
                check_value($sformatf("tri_rd_data[%0d]", a), tri_rd_data, m_tri[a]);
            end
        end
    endtask

    // back to back requests with each response due two cycles later
    task automatic check_lookups();
        int ids [$];
        int k;
        for (int i = 0; i < INST_NUM; i++) begin
            if (m_inst_ok[i]) ids.push_back(i);
        end
        for (int c = 0; c < ids.size() + 2; c++) begin
            check_value("draw_rsp_valid", draw_rsp_valid, c >= 2);
            if (c >= 2) begin
                k = ids[c - 2];
                check_value("draw_transform", draw_transform, m_xform[k]);
                check_value("draw_vert_base", draw_vert_base, m_vbase[m_link_v[k]]);
                check_value("draw_vert_count", draw_vert_count, m_vcnt[m_link_v[k]]);
                check_value("draw_tri_base", draw_tri_base, m_tbase[m_link_t[k]]);
                check_value("draw_tri_count", draw_tri_count, m_tcnt[m_link_t[k]]);
            end
            draw_valid   = (c < ids.size());
            draw_inst_id = (c < ids.size()) ? ids[c] : '0;
            next_cycle();
        end
    endtask

    function automatic row_t make_row(input logic [3:0] op, input int id, base, count,
                                      extra, busy_op, vbuf, tbuf);
        return {op, 8'(id), 10'(base), 9'(count), 4'(extra), 1'(busy_op), 4'(vbuf), 4'(tbuf)};
    endfunction

    // ========================================================================
    // main sequence
    // ========================================================================
    initial begin
        sck = 1'b0;
        rst = 1'b1;
        {opcode_valid, vert_hdr_valid, vert_valid, tri_hdr_valid, tri_valid} = '0;
        {inst_valid, draw_valid, opcode, vert_buf_id, inst_vbuf, tri_buf_id} = '0;
        {inst_tbuf, vert_base, vert_rd_addr, tri_base, tri_rd_addr} = '0;
        {vert_count, tri_count, vert_in, tri_in, inst_id_in, draw_inst_id} = '0;
        transform_in = '0;
        lfsr_state   = 32'h48164c48;
        for (int i = 0; i < VBUF_NUM; i++) {m_vbase[i], m_vcnt[i]} = '0;
        for (int i = 0; i < TBUF_NUM; i++) {m_tbase[i], m_tcnt[i]} = '0;

        rows.push_back(make_row(OP_VERT_HDR, 0, 100, 20, 0, 0, 0, 0));
        rows.push_back(make_row(OP_VERT_HDR, 1, 1016, 16, 2, 0, 0, 0)); // wraps
        rows.push_back(make_row(OP_TRI_HDR, 3, 50, 0, 0, 0, 0, 0));     // empty
        rows.push_back(make_row(OP_TRI_HDR, 0, 200, 12, 3, 0, 0, 0));
        rows.push_back(make_row(OP_TRI_HDR, 1, 1020, 9, 0, 0, 0, 0));
        rows.push_back(make_row(CHECK_ALL, 0, 0, 0, 0, 0, 0, 0));
        rows.push_back(make_row(OP_CREATE_INST, 5, 0, 0, 0, 0, 0, 0));
        rows.push_back(make_row(OP_CREATE_INST, 9, 0, 0, 0, 0, 1, 3));
        rows.push_back(make_row(OP_CREATE_INST, 63, 0, 0, 0, 0, 1, 1));
        rows.push_back(make_row(OP_CREATE_INST, 0, 0, 0, 0, 0, 0, 7)); // unused tbuf
        rows.push_back(make_row(CHECK_ALL, 0, 0, 0, 0, 0, 0, 0));
        rows.push_back(make_row(OP_VERT_HDR, 2, 100, 8, 4, 1, 0, 0)); // excess over buf 0
        rows.push_back(make_row(CHECK_ALL, 0, 0, 0, 0, 0, 0, 0));
        rows.push_back(make_row(OP_UPDATE_INST, 9, 0, 0, 0, 0, 5, 5));
        rows.push_back(make_row(CHECK_ALL, 0, 0, 0, 0, 0, 0, 0));
        rows.push_back(make_row(OP_WIPE, 0, 0, 0, 0, 0, 0, 0));
        rows.push_back(make_row(CHECK_ALL, 0, 0, 0, 0, 0, 0, 0));
        rows.push_back(make_row(OP_UPDATE_INST, 63, 0, 0, 0, 0, 2, 2));
        rows.push_back(make_row(CHECK_ALL, 0, 0, 0, 0, 0, 0, 0));

        repeat (3) @(posedge sck);
        #1;
        rst = 1'b0;

        foreach (rows[i]) begin
            case (rows[i].op)
                OP_VERT_HDR, OP_TRI_HDR:        load_buffer(rows[i]);
                OP_CREATE_INST, OP_UPDATE_INST: instance_cmd(rows[i]);
                OP_WIPE:                        wipe_tables();
                CHECK_ALL: begin
                    check_memories();
                    check_lookups();
                end
                default: stop_with_failure("command table holds an unknown row");
            endcase
        end

        if (busy === 1'b0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            stop_with_failure("busy still high after the last command");
        end
    end

endmodule

//--- list.f
rtl/scene_pkg.sv
rtl/sdp_ram.sv
rtl/desc_table.sv
rtl/scene_loader.sv
rtl/inst_lookup.sv
rtl/scene_mem.sv
testbench/tb_scene_mem.sv
